/* mem_select_top.f */
hw/mem_select_pkg.sv
hw/bank_select.sv
hw/host_port.sv
hw/bank_ram.sv
hw/engine_read_mux.sv
hw/mem_select_top.sv
tests/mem_select_tb.sv

/* tests/mem_select_tb.sv */
`timescale 1ns/1ps

module mem_select_tb;

  localparam int NUM_BANKS = mem_select_pkg::DEF_NUM_BANKS;

  logic                      clk2 = 1'b0;
  logic                      rst_n;
  mem_select_pkg::eng_wr_t   eng_wr;
  mem_select_pkg::bank_id_t  wt_bank;
  mem_select_pkg::addr_t     rd_addr;
  mem_select_pkg::bank_id_t  rd_bank;
  mem_select_pkg::bank_id_t  top_mem_sel;
  logic                      mem_sel_override;
  mem_select_pkg::word_t     doutb;
  logic                      host_req;
  mem_select_pkg::host_cmd_t host_cmd;
  logic                      host_ack;
  mem_select_pkg::word_t     host_rdata;

  integer seed = 32'h9da0_887f;
  // expected contents by bank number and address
  mem_select_pkg::word_t model [16][2048];

  mem_select_top #(.NUM_BANKS(NUM_BANKS)) dut (.*);

  // 100 ns period
  always #50 clk2 = ~clk2;

  ////////////////////////////////////////
  // checks and helpers
  ////////////////////////////////////////

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input mem_select_pkg::word_t got,
                            input mem_select_pkg::word_t want);
    if (got !== want) begin
      fail_stop($sformatf("FAIL %s got %h expected %h", name, got, want));
    end
  endtask

  task automatic check_ack(input logic got, input logic want);
    if (got !== want) begin
      fail_stop($sformatf("FAIL host_ack got %h expected %h", got, want));
    end
  endtask

  // unmapped numbers read as zero
  function automatic mem_select_pkg::word_t expect_word(input int bank,
                                                         input mem_select_pkg::addr_t addr);
    if (bank >= 1 && bank <= NUM_BANKS) begin
      return model[bank][addr];
    end else begin
      return '0;
    end
  endfunction

  // bank that a select really hits once the override is applied
  function automatic int eff_bank(input int sel);
    return mem_sel_override ? int'(top_mem_sel) : sel;
  endfunction

  function automatic mem_select_pkg::word_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[59:0];
  endfunction

  // ack is looked at on the falling edge
  task automatic wait_ack(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk2);
    while (host_ack !== level) begin
      if (cycles == 10) begin
        fail_stop($sformatf("timeout waiting for %s", what));
      end else begin
        cycles++;
        @(negedge clk2);
      end
    end
  endtask

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  // one-cycle write pulse
  // model follows the effective bank
  task automatic eng_write(input mem_select_pkg::bank_id_t bank,
                           input mem_select_pkg::addr_t addr,
                           input mem_select_pkg::word_t data);
    mem_select_pkg::eng_wr_t req;
    req.we        = 1'b1;
    req.addr      = addr;
    req.data_high = data[59:30];
    req.data_low  = data[29:0];
    @(posedge clk2);
    eng_wr  <= req;
    wt_bank <= bank;
    @(posedge clk2);
    eng_wr.we <= 1'b0;
    model[eff_bank(bank)][addr] = data;
  endtask

  // back-to-back reads with one bank per nibble of banks
  // lowest nibble goes first
  // each result is checked exactly one edge after its read is sampled
  task automatic read_seq(input logic [63:0] banks, input int n,
                          input mem_select_pkg::addr_t addr);
    mem_select_pkg::word_t    want [16];
    mem_select_pkg::bank_id_t bank;
    for (int k = 0; k <= n; k++) begin
      @(posedge clk2);
      if (k < n) begin
        bank = banks[4*k +: 4];
        rd_bank <= bank;
        rd_addr <= addr;
        want[k] = expect_word(eff_bank(bank), addr);
      end
      @(negedge clk2);
      if (k > 0) begin
        check_word("doutb", doutb, want[k-1]);
      end
    end
  endtask

  // one full four-phase exchange
  task automatic host_access(input mem_select_pkg::bank_id_t bank, input logic we,
                             input mem_select_pkg::addr_t addr,
                             input mem_select_pkg::word_t data);
    mem_select_pkg::host_cmd_t cmd;
    mem_select_pkg::word_t     want;
    cmd.we    = we;
    cmd.addr  = addr;
    cmd.wdata = data;
    // old word is expected even for a write
    want = expect_word(bank, addr);
    // command and bank settle a cycle ahead of req
    @(posedge clk2);
    host_cmd    <= cmd;
    top_mem_sel <= bank;
    @(posedge clk2);
    host_req <= 1'b1;
    wait_ack(1'b1, "host_ack to rise");
    check_word("host_rdata", host_rdata, want);
    // ack holds while req stays high
    repeat (2) begin
      @(negedge clk2);
      check_ack(host_ack, 1'b1);
    end
    @(posedge clk2);
    host_req <= 1'b0;
    wait_ack(1'b0, "host_ack to fall");
    model[bank][addr] = we ? data : model[bank][addr];
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk2);
    check_word("doutb", doutb, '0);
    check_ack(host_ack, 1'b0);
  endtask

  task automatic test_engine();
    for (int b = 1; b <= NUM_BANKS; b++) begin
      eng_write(mem_select_pkg::bank_id_t'(b), 11'h2a5, rand_word());
    end
    // ascending order first and shuffled after it
    read_seq(64'h9_8765_4321, 9, 11'h2a5);
    read_seq(64'h1_3579_2468, 9, 11'h2a5);
  endtask

  task automatic test_unmapped();
    eng_write(4'd0, 11'h2a5, rand_word());
    eng_write(4'd12, 11'h2a5, rand_word());
    read_seq(64'h9_8765_4321, 9, 11'h2a5);
    read_seq(64'hc0, 2, 11'h2a5);
  endtask

  task automatic test_override();
    eng_write(4'd2, 11'h13c, rand_word());
    eng_write(4'd5, 11'h13c, rand_word());
    @(posedge clk2);
    top_mem_sel      <= 4'd5;
    mem_sel_override <= 1'b1;
    // lands on bank 5 while bank 2 keeps its word
    eng_write(4'd2, 11'h13c, rand_word());
    read_seq(64'h7c2, 3, 11'h13c);
    @(posedge clk2);
    mem_sel_override <= 1'b0;
    read_seq(64'h52, 2, 11'h13c);
  endtask

  task automatic test_host();
    eng_write(4'd3, 11'h7ff, rand_word());
    host_access(4'd3, 1'b1, 11'h7ff, rand_word());
    eng_write(4'd7, 11'h7ff, rand_word());
    host_access(4'd7, 1'b0, 11'h7ff, '0);
    host_access(4'd0, 1'b0, 11'h7ff, '0);
    host_access(4'd13, 1'b1, 11'h7ff, rand_word());
    read_seq(64'h73, 2, 11'h7ff);
  endtask

  initial begin
    rst_n            = 1'b0;
    eng_wr           = '0;
    wt_bank          = '0;
    rd_addr          = '0;
    // a mapped read bank is selected while reset is held
    rd_bank          = 4'd1;
    top_mem_sel      = '0;
    mem_sel_override = 1'b0;
    host_req         = 1'b0;
    host_cmd         = '0;
    repeat (5) @(posedge clk2);
    rst_n <= 1'b1;
    test_reset();
    test_engine();
    test_unmapped();
    test_override();
    test_host();
    $display("Test OK");
    $finish;
  end

endmodule

/* hw/mem_select_top.sv */
`timescale 1ns/1ps

module mem_select_top #(
  parameter int NUM_BANKS = mem_select_pkg::DEF_NUM_BANKS
) (
  input  logic                      clk2,
  input  logic                      rst_n,
  // engine side
  input  mem_select_pkg::eng_wr_t   eng_wr,
  input  mem_select_pkg::bank_id_t  wt_bank,
  input  mem_select_pkg::addr_t     rd_addr,
  input  mem_select_pkg::bank_id_t  rd_bank,
  input  mem_select_pkg::bank_id_t  top_mem_sel,
  input  logic                      mem_sel_override,
  output mem_select_pkg::word_t     doutb,
  // host side
  input  logic                      host_req,
  input  mem_select_pkg::host_cmd_t host_cmd,
  output logic                      host_ack,
  output mem_select_pkg::word_t     host_rdata
);

  // engine write path
  logic [NUM_BANKS-1:0]     bank_we;
  mem_select_pkg::word_t    wr_word;
  mem_select_pkg::bank_id_t eff_rd_bank;

  // host path, shared by all banks except the enable
  logic [NUM_BANKS-1:0]     host_en;
  logic                     host_we;
  mem_select_pkg::addr_t    host_addr;
  mem_select_pkg::word_t    host_wdata;

  // per-bank read words
  mem_select_pkg::word_t    bank_rd_word    [NUM_BANKS];
  mem_select_pkg::word_t    bank_host_rdata [NUM_BANKS];

  ////////////////////////////////////////
  // input side
  ////////////////////////////////////////

  bank_select #(.NUM_BANKS(NUM_BANKS)) u_bank_select (
    .clk2             (clk2),
    .rst_n            (rst_n),
    .eng_wr           (eng_wr),
    .wt_bank          (wt_bank),
    .rd_bank          (rd_bank),
    .top_mem_sel      (top_mem_sel),
    .mem_sel_override (mem_sel_override),
    .bank_we          (bank_we),
    .wr_word          (wr_word),
    .eff_rd_bank      (eff_rd_bank)
  );

  host_port #(.NUM_BANKS(NUM_BANKS)) u_host_port (
    .clk2            (clk2),
    .rst_n           (rst_n),
    .host_req        (host_req),
    .host_cmd        (host_cmd),
    .top_mem_sel     (top_mem_sel),
    .bank_host_rdata (bank_host_rdata),
    .host_ack        (host_ack),
    .host_rdata      (host_rdata),
    .host_en         (host_en),
    .host_we         (host_we),
    .host_addr       (host_addr),
    .host_wdata      (host_wdata)
  );

  ////////////////////////////////////////
  // bank memories
  ////////////////////////////////////////

  // index i serves bank number i+1
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    bank_ram u_bank_ram (
      .clk2       (clk2),
      .we         (bank_we[i]),
      .wr_addr    (eng_wr.addr),
      .wr_word    (wr_word),
      .rd_addr    (rd_addr),
      .host_en    (host_en[i]),
      .host_we    (host_we),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .rd_word    (bank_rd_word[i]),
      .host_rdata (bank_host_rdata[i])
    );
  end

  ////////////////////////////////////////
  // output side
  ////////////////////////////////////////

  engine_read_mux #(.NUM_BANKS(NUM_BANKS)) u_engine_read_mux (
    .clk2         (clk2),
    .rst_n        (rst_n),
    .eff_rd_bank  (eff_rd_bank),
    .bank_rd_word (bank_rd_word),
    .doutb        (doutb)
  );

endmodule

/* hw/engine_read_mux.sv */
`timescale 1ns/1ps

module engine_read_mux #(
  parameter int NUM_BANKS = 9
) (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  mem_select_pkg::bank_id_t eff_rd_bank,
  input  mem_select_pkg::word_t    bank_rd_word [NUM_BANKS],
  output mem_select_pkg::word_t    doutb
);

  // read select delayed to line up with the bank output register
  mem_select_pkg::bank_id_t rd_sel_q;

  ////////////////////////////////////////
  // select pipeline
  ////////////////////////////////////////

  // cleared to zero so doutb reads zero out of reset
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_sel_q <= '0;
    end else begin
      rd_sel_q <= eff_rd_bank;
    end
  end

  ////////////////////////////////////////
  // output mux
  ////////////////////////////////////////

  // bank number i+1 sits at index i
  // unmapped numbers fall through to zero
  always_comb begin
    doutb = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (rd_sel_q == mem_select_pkg::bank_id_t'(i + 1)) begin
        doutb = bank_rd_word[i];
      end
    end
  end

endmodule

/* hw/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram (
  input  logic                  clk2,
  input  logic                  we,
  input  mem_select_pkg::addr_t wr_addr,
  input  mem_select_pkg::word_t wr_word,
  input  mem_select_pkg::addr_t rd_addr,
  input  logic                  host_en,
  input  logic                  host_we,
  input  mem_select_pkg::addr_t host_addr,
  input  mem_select_pkg::word_t host_wdata,
  output mem_select_pkg::word_t rd_word,
  output mem_select_pkg::word_t host_rdata
);

  // depth follows the address width, 2048 words
  localparam int DEPTH = 1 << $bits(mem_select_pkg::addr_t);

  mem_select_pkg::word_t mem [DEPTH];

  ////////////////////////////////////////
  // engine port
  ////////////////////////////////////////

  // read register, data valid one cycle after the address
  always_ff @(posedge clk2) begin
    rd_word <= mem[rd_addr];
  end

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // engine write first, host write after it
  // so the host wins when both hit one word on the same edge
  always_ff @(posedge clk2) begin
    if (we) begin
      mem[wr_addr] <= wr_word;
    end
    if (host_en && host_we) begin
      mem[host_addr] <= host_wdata;
    end
  end

  ////////////////////////////////////////
  // host read
  ////////////////////////////////////////

  // current contents at the host address
  // the sequencer samples this on the same edge that writes, i.e. read-before-write
  assign host_rdata = mem[host_addr];

endmodule

/* hw/host_port.sv */
`timescale 1ns/1ps

module host_port #(
  parameter int NUM_BANKS = 9
) (
  input  logic                      clk2,
  input  logic                      rst_n,
  input  logic                      host_req,
  input  mem_select_pkg::host_cmd_t host_cmd,
  input  mem_select_pkg::bank_id_t  top_mem_sel,
  input  mem_select_pkg::word_t     bank_host_rdata [NUM_BANKS],
  output logic                      host_ack,
  output mem_select_pkg::word_t     host_rdata,
  output logic [NUM_BANKS-1:0]      host_en,
  output logic                      host_we,
  output mem_select_pkg::addr_t     host_addr,
  output mem_select_pkg::word_t     host_wdata
);

  mem_select_pkg::host_state_e state;
  // command and bank held for the whole exchange
  mem_select_pkg::host_cmd_t   cmd_q;
  mem_select_pkg::bank_id_t    bank_q;
  // read word of the latched bank, zero when unmapped
  mem_select_pkg::word_t       sel_rdata;

  ////////////////////////////////////////
  // four-phase sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mem_select_pkg::HOST_IDLE;
      host_ack <= 1'b0;
    end else begin
      case (state)
        mem_select_pkg::HOST_IDLE: begin
          if (host_req) begin
            state <= mem_select_pkg::HOST_ACCESS;
          end
        end
        // bank does its access at the end of this cycle
        mem_select_pkg::HOST_ACCESS: begin
          state    <= mem_select_pkg::HOST_ACK;
          host_ack <= 1'b1;
        end
        // hold ack until the host lets go of req
        mem_select_pkg::HOST_ACK: begin
          if (!host_req) begin
            state    <= mem_select_pkg::HOST_IDLE;
            host_ack <= 1'b0;
          end
        end
        default: begin
          state <= mem_select_pkg::HOST_IDLE;
        end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk2) begin
    if (state == mem_select_pkg::HOST_IDLE && host_req) begin
      cmd_q  <= host_cmd;
      bank_q <= top_mem_sel;
    end
    // word seen before the write edge, so a write returns the old data
    if (state == mem_select_pkg::HOST_ACCESS) begin
      host_rdata <= sel_rdata;
    end
  end

  ////////////////////////////////////////
  // bank side
  ////////////////////////////////////////

  // one-cycle enable pulse towards the latched bank only
  always_comb begin
    host_en   = '0;
    sel_rdata = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_q == mem_select_pkg::bank_id_t'(i + 1)) begin
        host_en[i] = (state == mem_select_pkg::HOST_ACCESS);
        sel_rdata  = bank_host_rdata[i];
      end
    end
  end

  assign host_we    = cmd_q.we;
  assign host_addr  = cmd_q.addr;
  assign host_wdata = cmd_q.wdata;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // ack may only drop once the host has released req
  a_ack_hold : assert property (
    @(posedge clk2) disable iff (!rst_n)
    $fell(host_ack) |-> !$past(host_req)
  );

  a_en_onehot : assert property (
    @(posedge clk2) disable iff (!rst_n)
    $onehot0(host_en)
  );

endmodule

/* hw/bank_select.sv */
`timescale 1ns/1ps

module bank_select #(
  parameter int NUM_BANKS = 9
) (
  input  logic                     clk2,
  input  logic                     rst_n,
  input  mem_select_pkg::eng_wr_t  eng_wr,
  input  mem_select_pkg::bank_id_t wt_bank,
  input  mem_select_pkg::bank_id_t rd_bank,
  input  mem_select_pkg::bank_id_t top_mem_sel,
  input  logic                     mem_sel_override,
  output logic [NUM_BANKS-1:0]     bank_we,
  output mem_select_pkg::word_t    wr_word,
  output mem_select_pkg::bank_id_t eff_rd_bank
);

  // write bank after the override has been applied
  mem_select_pkg::bank_id_t eff_wt_bank;

  ////////////////////////////////////////
  // select resolution
  ////////////////////////////////////////

  // top level takes both engine selects when override is set
  assign eff_wt_bank = mem_sel_override ? top_mem_sel : wt_bank;
  assign eff_rd_bank = mem_sel_override ? top_mem_sel : rd_bank;

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  // bit i enables bank number i+1
  // numbers 0 and above NUM_BANKS match no bit, so the write is dropped
  always_comb begin
    bank_we = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (eff_wt_bank == mem_select_pkg::bank_id_t'(i + 1)) begin
        bank_we[i] = eng_wr.we;
      end
    end
  end

  // high half lands in the upper bits
  assign wr_word = {eng_wr.data_high, eng_wr.data_low};

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // at most one bank takes an engine write per edge
  a_we_onehot : assert property (
    @(posedge clk2) disable iff (!rst_n)
    $onehot0(bank_we)
  );

endmodule

/* hw/mem_select_pkg.sv */
package mem_select_pkg;

  ////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////

  // bank number, 1..NUM_BANKS are mapped, 0 never is
  typedef logic [3:0] bank_id_t;

  // word address inside one bank, 2048 words deep
  typedef logic [10:0] addr_t;

  // one stored sample word
  typedef logic [59:0] word_t;

  // the engine hands a word over as two halves
  typedef logic [29:0] half_t;

  ////////////////////////////////////////
  // grouped request fields
  ////////////////////////////////////////

  // engine write request, sampled every clock
  typedef struct packed {
    logic  we;
    addr_t addr;
    half_t data_high;
    half_t data_low;
  } eng_wr_t;

  // host command, held stable for a whole req/ack exchange
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } host_cmd_t;

  // host sequencer states
  typedef enum logic [1:0] {
    HOST_IDLE,
    HOST_ACCESS,
    HOST_ACK
  } host_state_e;

  // bank count used when the top level is not overridden
  localparam int DEF_NUM_BANKS = 9;

endpackage
